/* dv/bootPatterns.hex */
// Lines of one word: image words 0 to 15, word 0 first.
// Lines of four: kind (0 read, 1 write), address, write data, expected read data.
1A2B
C3D4
5E6F
7081
92A3
B4C5
D6E7
F809
0F1E
2D3C
4B5A
6978
8796
A5B4
C3D2
E1F0
0000 0003 0000 7081
0001 0040 1234 0000
0000 0040 0000 1234
0001 000A BEEF 0000
0000 000A 0000 BEEF
0000 000F 0000 E1F0

/* dv/spiEepromModel.sv */
// Behavioral SPI EEPROM for the testbench. Captures the frame header on
// rising SPI clock edges and serves image words on MISO, MSB first.
`timescale 1ns/1ps

module spiEepromModel #(
	parameter int IMAGE_WORDS = 16
) (
	input  logic              i_spiClk,
	input  logic              i_spiMosi,
	input  logic              i_spiCsN,
	output logic              o_spiMiso,
	input  uprocPkg::memDataT i_image [IMAGE_WORDS],
	output logic              o_hdrSeen,
	output uprocPkg::spiCmdT  o_rxCmd,
	output uprocPkg::memAddrT o_rxAddr
);

	// Command byte plus 16-bit start address.
	localparam int HDR_BITS = 24;

	int          bitCnt = 0;
	logic [23:0] hdrShift = '0;
	logic        hdrSeen = 1'b0;
	logic        miso = 1'b0;
	logic        hdrOk;

	// Data bit n of the stream, zero past the image.
	function automatic logic imageBit(input int n);
		if ((n / 16) >= IMAGE_WORDS) begin
			return 1'b0;
		end
		return i_image[n / 16][15 - (n % 16)];
	endfunction

	// Rising edge takes MOSI. Chip select high restarts the frame.
	always @(posedge i_spiClk or posedge i_spiCsN) begin
		if (i_spiCsN) begin
			bitCnt <= 0;
		end else begin
			if (bitCnt < HDR_BITS) begin
				hdrShift <= {hdrShift[22:0], i_spiMosi};
			end
			if (bitCnt == HDR_BITS - 1) begin
				hdrSeen <= 1'b1;
			end
			bitCnt <= bitCnt + 1;
		end
	end

	// Only a proper read command gets data back.
	assign hdrOk = (o_rxCmd == uprocPkg::SPI_READ_CMD) && (o_rxAddr == '0);

	// Falling edge presents the next data bit.
	always @(negedge i_spiClk) begin
		if (!i_spiCsN && (bitCnt >= HDR_BITS) && hdrOk) begin
			miso <= imageBit(bitCnt - HDR_BITS);
		end else begin
			miso <= 1'b0;
		end
	end

	assign o_spiMiso = miso;
	assign o_hdrSeen = hdrSeen;
	assign o_rxCmd   = hdrShift[23:16];
	assign o_rxAddr  = hdrShift[15:0];

endmodule

/* dv/uprocBootTb.sv */
// Testbench for the boot and pause subsystem. Boots from the EEPROM model,
// checks the SRAM copy, then runs host records from the patterns file.
`timescale 1ns/1ps

module uprocBootTb;

	localparam int IMAGE_WORDS  = 16;
	localparam int REC_COUNT    = 6;
	localparam int PAT_WORDS    = IMAGE_WORDS + 4 * REC_COUNT;
	localparam int BOOT_TIMEOUT = 5000;
	localparam int WAIT_TIMEOUT = 50;

	logic              sysClk;
	logic              rstN;
	logic              spiMiso;
	logic              spiClk;
	logic              spiMosi;
	logic              spiCsN;
	uprocPkg::memAddrT memAddr;
	uprocPkg::memDataT memWrData;
	logic              memWr;
	logic              memEn;
	uprocPkg::memDataT memRdData = '0;
	uprocPkg::memReqT  hostReq;
	logic              hostValid;
	logic              hostReady;
	uprocPkg::memDataT hostRdData;
	logic              hostRdValid;
	logic              hostPause;
	logic              pausePin;
	logic              smIsBooted;
	logic              smIsPaused;

	// Header as seen by the EEPROM model.
	logic              hdrSeen;
	uprocPkg::spiCmdT  rxCmd;
	uprocPkg::memAddrT rxAddr;

	uprocPkg::memDataT patMem [PAT_WORDS];
	uprocPkg::memDataT image [IMAGE_WORDS];
	uprocPkg::memDataT sram [65536];
	logic [15:0]       lfsr;
	int                errCount;
	int                timeoutCount;

	uprocBoot #(
		.IMAGE_WORDS(IMAGE_WORDS)
	) u_dut (
		.i_spiMiso    (spiMiso),
		.o_spiClk     (spiClk),
		.o_spiMosi    (spiMosi),
		.o_spiCsN     (spiCsN),
		.o_memAddr    (memAddr),
		.o_memWrData  (memWrData),
		.o_memWr      (memWr),
		.o_memEn      (memEn),
		.i_memRdData  (memRdData),
		.i_hostReq    (hostReq),
		.i_hostValid  (hostValid),
		.o_hostReady  (hostReady),
		.o_hostRdData (hostRdData),
		.o_hostRdValid(hostRdValid),
		.i_hostPause  (hostPause),
		.i_pausePin   (pausePin),
		.o_smIsBooted (smIsBooted),
		.o_smIsPaused (smIsPaused),
		.i_sysClk     (sysClk),
		.i_rstN       (rstN)
	);

	spiEepromModel #(
		.IMAGE_WORDS(IMAGE_WORDS)
	) u_eeprom (
		.i_spiClk (spiClk),
		.i_spiMosi(spiMosi),
		.i_spiCsN (spiCsN),
		.o_spiMiso(spiMiso),
		.i_image  (image),
		.o_hdrSeen(hdrSeen),
		.o_rxCmd  (rxCmd),
		.o_rxAddr (rxAddr)
	);

	//--------------------------------------------------------------------------
	// Clock and SRAM model.
	//--------------------------------------------------------------------------

	initial begin
		sysClk = 1'b0;
		forever #4 sysClk = ~sysClk;
	end

	// One-cycle read latency. Filled from the address during reset.
	always @(posedge sysClk) begin
		if (!rstN) begin
			for (int i = 0; i < 65536; i++) begin
				sram[16'(i)] <= 16'(i) ^ 16'hA5A5;
			end
			memRdData <= '0;
		end else if (memEn && memWr) begin
			sram[memAddr] <= memWrData;
		end else if (memEn) begin
			memRdData <= sram[memAddr];
		end
	end

	//--------------------------------------------------------------------------
	// Helpers.
	//--------------------------------------------------------------------------

	task automatic expectWord(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got === exp) else begin
			$display("ERROR %s got 0x%04h expected 0x%04h at %0t", name, got, exp, $time);
			errCount++;
		end
	endtask

	// Galois LFSR, one step per bit.
	function automatic int takeBits(input int n);
		int val;
		val = 0;
		for (int i = 0; i < n; i++) begin
			val  = (val << 1) | int'(lfsr[0]);
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return val;
	endfunction

	task automatic waitPaused(input logic level);
		int cycles;
		cycles = 0;
		while ((smIsPaused !== level) && (cycles < WAIT_TIMEOUT)) begin
			// Host port stays closed until the paused state shows.
			if (level) begin
				expectWord("o_hostReady", 16'(hostReady), 16'h0000);
			end
			@(negedge sysClk);
			cycles++;
		end
		assert (smIsPaused === level) else begin
			$display("Timeout while waiting for the paused state to become %0d", level);
			timeoutCount++;
		end
	endtask

	task automatic setPause(input int src, input logic level);
		@(posedge sysClk);
		if (src == 1) begin
			pausePin <= level;
		end else begin
			hostPause <= level;
		end
		@(negedge sysClk);
	endtask

	task automatic issueRequest(input int rec);
		int base;
		base = IMAGE_WORDS + 4 * rec;
		@(posedge sysClk);
		hostReq   <= {patMem[base][0], patMem[base + 1], patMem[base + 2]};
		hostValid <= 1'b1;
		@(negedge sysClk);
	endtask

	// Waits for acceptance, then checks the response one cycle later.
	task automatic finishAccess(input int rec);
		int   base;
		int   cycles;
		logic isRead;
		base   = IMAGE_WORDS + 4 * rec;
		isRead = ~patMem[base][0];
		cycles = 0;
		while (!(hostValid && hostReady) && (cycles < WAIT_TIMEOUT)) begin
			@(negedge sysClk);
			cycles++;
		end
		assert (hostValid && hostReady) else begin
			$display("Timeout: host record %0d was never accepted", rec);
			timeoutCount++;
		end
		expectWord("o_smIsPaused", 16'(smIsPaused), 16'h0001);
		@(posedge sysClk);
		hostValid <= 1'b0;
		@(negedge sysClk);
		expectWord("o_hostRdValid", 16'(hostRdValid), 16'(isRead));
		if (isRead) begin
			expectWord("o_hostRdData", hostRdData, patMem[base + 3]);
		end else begin
			expectWord("sram", sram[patMem[base + 1]], patMem[base + 2]);
		end
	endtask

	//--------------------------------------------------------------------------
	// Main sequence.
	//--------------------------------------------------------------------------

	initial begin
		int gap;
		int src;
		int cycles;
		rstN         = 1'b0;
		hostReq      = '0;
		hostValid    = 1'b0;
		hostPause    = 1'b0;
		pausePin     = 1'b0;
		lfsr         = 16'd34856;
		errCount     = 0;
		timeoutCount = 0;
		src          = 0;
		$readmemh("dv/bootPatterns.hex", patMem);
		for (int i = 0; i < IMAGE_WORDS; i++) begin
			image[i] = patMem[i];
		end

		// Outputs idle while reset is held.
		repeat (3) @(posedge sysClk);
		@(negedge sysClk);
		expectWord("o_spiCsN", 16'(spiCsN), 16'h0001);
		expectWord("o_memEn", 16'(memEn), 16'h0000);
		expectWord("o_smIsBooted", 16'(smIsBooted), 16'h0000);
		expectWord("o_smIsPaused", 16'(smIsPaused), 16'h0000);
		expectWord("o_hostReady", 16'(hostReady), 16'h0000);
		expectWord("o_hostRdValid", 16'(hostRdValid), 16'h0000);
		@(posedge sysClk);
		rstN <= 1'b1;

		cycles = 0;
		while (!smIsBooted && (cycles < BOOT_TIMEOUT)) begin
			@(negedge sysClk);
			cycles++;
		end
		assert (smIsBooted) else begin
			$display("Timeout: the booted indicator never rose");
			timeoutCount++;
		end

		// Read command 03 at address zero, then the image copy.
		expectWord("hdrSeen", 16'(hdrSeen), 16'h0001);
		expectWord("rxCmd", 16'(rxCmd), 16'h0003);
		expectWord("rxAddr", rxAddr, 16'h0000);
		for (int i = 0; i < IMAGE_WORDS; i++) begin
			expectWord("sram", sram[16'(i)], image[i]);
		end

		// Two records per pause window, the first one issued early.
		for (int r = 0; r < REC_COUNT / 2; r++) begin
			gap = takeBits(2);
			repeat (gap + 1) @(negedge sysClk);
			issueRequest(2 * r);
			repeat (gap + 2) begin
				expectWord("o_hostReady", 16'(hostReady), 16'h0000);
				@(negedge sysClk);
			end
			// First source drawn, then alternated so pin and host both run.
			if (r == 0) begin
				src = takeBits(1);
			end else begin
				src = 1 - src;
			end
			setPause(src, 1'b1);
			waitPaused(1'b1);
			finishAccess(2 * r);
			gap = takeBits(2);
			repeat (gap + 1) @(negedge sysClk);
			issueRequest(2 * r + 1);
			finishAccess(2 * r + 1);
			setPause(src, 1'b0);
			waitPaused(1'b0);
		end

		$display("Run complete: %0d value errors, %0d timeouts", errCount, timeoutCount);
		if ((errCount == 0) && (timeoutCount == 0)) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* logic/bootImage.sv */
// Boot loader. Reads the image from the SPI EEPROM after reset and
// writes it word by word into SRAM through a valid/ready write port.
`timescale 1ns/1ps

module bootImage #(
	parameter int IMAGE_WORDS = 16
) (
	// Storage chip connections.
	input  logic              i_spiMiso,
	output logic              o_spiClk,
	output logic              o_spiMosi,
	output logic              o_spiCsN,

	// Boot write port to the memory controller.
	output uprocPkg::memReqT  o_memReq,
	output logic              o_memValid,
	input  logic              i_memReady,

	// Boot state indicator.
	output logic              o_nowBooted,

	// Common signals.
	input  logic              i_sysClk,
	input  logic              i_rstN
);

	// Command byte plus start address, shifted out as one frame header.
	localparam int TX_BITS = $bits(uprocPkg::spiCmdT) + $bits(uprocPkg::memAddrT);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CMD,
		ST_ADDR,
		ST_DATA,
		ST_WRITE,
		ST_DONE
	} bootStateT;

	logic [1:0]          rstSync;
	logic                rstN;
	bootStateT           state;
	logic                spiClk;
	logic                spiCsN;
	logic [3:0]          bitCnt;
	logic                lastBit;
	logic                lastWord;
	uprocPkg::memAddrT   wordIdx;
	logic                memValid;
	logic                nowBooted;
	logic [TX_BITS-1:0]  txShift;
	uprocPkg::memDataT   rxShift;

	//--------------------------------------------------------------------------
	// Reset synchronizer.
	//--------------------------------------------------------------------------

	// Asserts at once, releases two clocks later.
	always_ff @(posedge i_sysClk or negedge i_rstN) begin
		if (!i_rstN) begin
			rstSync <= 2'b00;
		end else begin
			rstSync <= {rstSync[0], 1'b1};
		end
	end
	assign rstN = rstSync[1];

	//--------------------------------------------------------------------------
	// Control FSM.
	//--------------------------------------------------------------------------

	// Command is 8 bits, address and data words are 16.
	assign lastBit  = (state == ST_CMD) ? (bitCnt == 4'd7) : (bitCnt == 4'd15);
	assign lastWord = (wordIdx == uprocPkg::memAddrT'(IMAGE_WORDS - 1));

	always_ff @(posedge i_sysClk or negedge rstN) begin
		if (!rstN) begin
			state     <= ST_IDLE;
			spiClk    <= 1'b0;
			spiCsN    <= 1'b1;
			bitCnt    <= '0;
			wordIdx   <= '0;
			memValid  <= 1'b0;
			nowBooted <= 1'b0;
		end else begin
			case (state)
				// Select the EEPROM and start the frame.
				ST_IDLE: begin
					spiCsN <= 1'b0;
					bitCnt <= '0;
					state  <= ST_CMD;
				end
				// SPI clock toggles every system clock.
				ST_CMD, ST_ADDR, ST_DATA: begin
					spiClk <= ~spiClk;
					if (spiClk) begin
						// Falling edge ends a bit.
						bitCnt <= bitCnt + 4'd1;
						if (lastBit) begin
							bitCnt <= '0;
							case (state)
								ST_CMD:  state <= ST_ADDR;
								ST_ADDR: state <= ST_DATA;
								default: begin
									state    <= ST_WRITE;
									memValid <= 1'b1;
								end
							endcase
						end
					end
				end
				// SPI clock stays low until the word is taken.
				ST_WRITE: begin
					if (i_memReady) begin
						memValid <= 1'b0;
						if (lastWord) begin
							spiCsN    <= 1'b1;
							nowBooted <= 1'b1;
							state     <= ST_DONE;
						end else begin
							wordIdx <= wordIdx + 1'b1;
							state   <= ST_DATA;
						end
					end
				end
				// Held until the next reset.
				ST_DONE: begin
					state <= ST_DONE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	//--------------------------------------------------------------------------
	// Shift registers.
	//--------------------------------------------------------------------------

	// MOSI moves on falling edges, MISO is taken on rising edges.
	always_ff @(posedge i_sysClk) begin
		if (state == ST_IDLE) begin
			txShift <= {uprocPkg::SPI_READ_CMD, uprocPkg::memAddrT'(0)};
		end else if (spiClk && ((state == ST_CMD) || (state == ST_ADDR))) begin
			txShift <= {txShift[TX_BITS-2:0], 1'b0};
		end
		if (!spiClk && (state == ST_DATA)) begin
			rxShift <= {rxShift[$bits(rxShift)-2:0], i_spiMiso};
		end
	end

	// Outputs.
	assign o_spiClk      = spiClk;
	assign o_spiCsN      = spiCsN;
	assign o_spiMosi     = txShift[TX_BITS-1] & ~spiCsN;
	assign o_memReq.wr   = 1'b1;
	assign o_memReq.addr = wordIdx;
	assign o_memReq.data = rxShift;
	assign o_memValid    = memValid;
	assign o_nowBooted   = nowBooted;

	// A write is only offered inside an open EEPROM frame.
	pValidInFrame: assert property (@(posedge i_sysClk) disable iff (!rstN)
		($rose(o_memValid) && !o_nowBooted) |-> !o_spiCsN);

endmodule

/* logic/memController.sv */
// SRAM bus arbiter. The boot loader owns the bus before boot, the host
// port afterwards while paused. Host reads return one cycle after accept.
`timescale 1ns/1ps

module memController (
	// Boot loader write port.
	input  uprocPkg::memReqT  i_bootReq,
	input  logic              i_bootValid,
	output logic              o_bootReady,

	// Host debug port.
	input  uprocPkg::memReqT  i_hostReq,
	input  logic              i_hostValid,
	output logic              o_hostReady,
	output uprocPkg::memDataT o_hostRdData,
	output logic              o_hostRdValid,

	// Subsystem state.
	input  logic              i_isBooted,
	input  logic              i_isPaused,

	// SRAM bus.
	output uprocPkg::memAddrT o_memAddr,
	output uprocPkg::memDataT o_memWrData,
	output logic              o_memWr,
	output logic              o_memEn,
	input  uprocPkg::memDataT i_memRdData,

	// Common signals.
	input  logic              i_sysClk,
	input  logic              i_rstN
);

	logic [1:0]        rstSync;
	logic              rstN;
	logic              bootReady;
	logic              hostOwns;
	logic              bootXfer;
	logic              hostXfer;
	logic              rdPending;
	uprocPkg::memReqT  busReq;

	// Reset synchronizer.
	always_ff @(posedge i_sysClk or negedge i_rstN) begin
		if (!i_rstN) begin
			rstSync <= 2'b00;
		end else begin
			rstSync <= {rstSync[0], 1'b1};
		end
	end
	assign rstN = rstSync[1];

	//--------------------------------------------------------------------------
	// Ownership and handshakes.
	//--------------------------------------------------------------------------

	// Boot side ready, registered so it stays low through reset.
	always_ff @(posedge i_sysClk or negedge rstN) begin
		if (!rstN) begin
			bootReady <= 1'b0;
		end else begin
			bootReady <= ~i_isBooted;
		end
	end

	// Bus belongs to the host once the image is in place.
	assign hostOwns    = i_isBooted;
	assign o_bootReady = bootReady;
	assign o_hostReady = i_isPaused & ~i_bootValid;

	assign bootXfer = i_bootValid & bootReady;
	assign hostXfer = i_hostValid & o_hostReady;

	//--------------------------------------------------------------------------
	// SRAM bus drive.
	//--------------------------------------------------------------------------

	assign busReq      = hostOwns ? i_hostReq : i_bootReq;
	assign o_memEn     = bootXfer | hostXfer;
	assign o_memWr     = o_memEn & busReq.wr;
	assign o_memAddr   = busReq.addr;
	assign o_memWrData = busReq.data;

	// Read response tracks an accepted host read by one cycle.
	always_ff @(posedge i_sysClk or negedge rstN) begin
		if (!rstN) begin
			rdPending <= 1'b0;
		end else begin
			rdPending <= hostXfer & ~i_hostReq.wr;
		end
	end

	// SRAM data arrives in the same cycle as the response.
	assign o_hostRdValid = rdPending;
	assign o_hostRdData  = i_memRdData;

	// Boot and host never get the bus in the same cycle.
	pOneReady: assert property (@(posedge i_sysClk) disable iff (!rstN)
		!(o_bootReady && o_hostReady));

endmodule

/* logic/pauseNetwork.sv */
// Pause network. Merges the synchronized pause pin with the host pause
// request and reports the paused state once the device is booted.
`timescale 1ns/1ps

module pauseNetwork (
	// Pause sources.
	input  logic i_pausePin,
	input  logic i_hostPause,

	// Boot state and resulting pause state.
	input  logic i_isBooted,
	output logic o_isPaused,

	// Common signals.
	input  logic i_sysClk,
	input  logic i_rstN
);

	logic [1:0] rstSync;
	logic       rstN;
	logic [1:0] pinSync;
	logic       startPause;
	logic       isPaused;

	// Reset synchronizer.
	always_ff @(posedge i_sysClk or negedge i_rstN) begin
		if (!i_rstN) begin
			rstSync <= 2'b00;
		end else begin
			rstSync <= {rstSync[0], 1'b1};
		end
	end
	assign rstN = rstSync[1];

	//--------------------------------------------------------------------------
	// Pause registers.
	//--------------------------------------------------------------------------

	// Pin is asynchronous, two flops before use.
	// Start-pause is either source, paused needs boot done too.
	always_ff @(posedge i_sysClk or negedge rstN) begin
		if (!rstN) begin
			pinSync    <= 2'b00;
			startPause <= 1'b0;
			isPaused   <= 1'b0;
		end else begin
			pinSync    <= {pinSync[0], i_pausePin};
			startPause <= pinSync[1] | i_hostPause;
			isPaused   <= startPause & i_isBooted;
		end
	end

	assign o_isPaused = isPaused;

	// Booted never drops, so paused always sits on a booted device.
	pPausedBooted: assert property (@(posedge i_sysClk) disable iff (!rstN)
		o_isPaused |-> i_isBooted);

endmodule

/* logic/uprocBoot.sv */
// Top level of the boot and pause subsystem. Connects the boot loader,
// the memory controller and the pause network.
`timescale 1ns/1ps

module uprocBoot #(
	parameter int IMAGE_WORDS = 16
) (
	// Storage chip (SPI EEPROM) connections.
	input  logic              i_spiMiso,
	output logic              o_spiClk,
	output logic              o_spiMosi,
	output logic              o_spiCsN,

	// Runtime chip (SRAM) connections.
	output uprocPkg::memAddrT o_memAddr,
	output uprocPkg::memDataT o_memWrData,
	output logic              o_memWr,
	output logic              o_memEn,
	input  uprocPkg::memDataT i_memRdData,

	// Host debug port.
	input  uprocPkg::memReqT  i_hostReq,
	input  logic              i_hostValid,
	output logic              o_hostReady,
	output uprocPkg::memDataT o_hostRdData,
	output logic              o_hostRdValid,
	input  logic              i_hostPause,

	// State machine connections.
	input  logic              i_pausePin,
	output logic              o_smIsBooted,
	output logic              o_smIsPaused,

	// Common signals.
	input  logic              i_sysClk,
	input  logic              i_rstN
);

	// Boot write port.
	uprocPkg::memReqT bootReq;
	logic             bootValid;
	logic             bootReady;

	// Subsystem state.
	logic             isBooted;
	logic             isPaused;

	//--------------------------------------------------------------------------
	// Boot loader, EEPROM to SRAM copy.
	bootImage #(
		.IMAGE_WORDS(IMAGE_WORDS)
	) BOOT_IMAGE (
		.i_spiMiso  (i_spiMiso),
		.o_spiClk   (o_spiClk),
		.o_spiMosi  (o_spiMosi),
		.o_spiCsN   (o_spiCsN),
		.o_memReq   (bootReq),
		.o_memValid (bootValid),
		.i_memReady (bootReady),
		.o_nowBooted(isBooted),
		.i_sysClk   (i_sysClk),
		.i_rstN     (i_rstN)
	);

	//--------------------------------------------------------------------------
	// Memory controller, SRAM bus owner select.
	memController MEM_CTRL (
		.i_bootReq    (bootReq),
		.i_bootValid  (bootValid),
		.o_bootReady  (bootReady),
		.i_hostReq    (i_hostReq),
		.i_hostValid  (i_hostValid),
		.o_hostReady  (o_hostReady),
		.o_hostRdData (o_hostRdData),
		.o_hostRdValid(o_hostRdValid),
		.i_isBooted   (isBooted),
		.i_isPaused   (isPaused),
		.o_memAddr    (o_memAddr),
		.o_memWrData  (o_memWrData),
		.o_memWr      (o_memWr),
		.o_memEn      (o_memEn),
		.i_memRdData  (i_memRdData),
		.i_sysClk     (i_sysClk),
		.i_rstN       (i_rstN)
	);

	//--------------------------------------------------------------------------
	// Pause network, pin and host pause sources.
	pauseNetwork PAUSE_NET (
		.i_pausePin (i_pausePin),
		.i_hostPause(i_hostPause),
		.i_isBooted (isBooted),
		.o_isPaused (isPaused),
		.i_sysClk   (i_sysClk),
		.i_rstN     (i_rstN)
	);

	// State indicator pins.
	assign o_smIsBooted = isBooted;
	assign o_smIsPaused = isPaused;

endmodule

/* logic/uprocPkg.sv */
// Shared types and constants of the boot and pause subsystem.
// Modules refer to these by scoped names such as uprocPkg::memReqT.

package uprocPkg;

	//--------------------------------------------------------------------------
	// Bus widths.
	//--------------------------------------------------------------------------

	// SRAM word address width.
	localparam int MEM_ADDR_BITS = 16;

	// SRAM and image data word width.
	localparam int MEM_DATA_BITS = 16;

	// SRAM word address.
	typedef logic [MEM_ADDR_BITS-1:0] memAddrT;

	// SRAM and image data word.
	typedef logic [MEM_DATA_BITS-1:0] memDataT;

	//--------------------------------------------------------------------------
	// Memory request word.
	//--------------------------------------------------------------------------

	// One SRAM access, as offered by a bus master.
	typedef struct packed {
		logic    wr;      // High for write, low for read.
		memAddrT addr;    // Target word address.
		memDataT data;    // Write data, ignored on reads.
	} memReqT;

	//--------------------------------------------------------------------------
	// SPI EEPROM commands.
	//--------------------------------------------------------------------------

	// EEPROM opcode byte.
	typedef logic [7:0] spiCmdT;

	// Sequential read, followed by a 16-bit start address.
	localparam spiCmdT SPI_READ_CMD = 8'h03;

endpackage

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module uprocBootTb -f uprocBoot.f -o uprocBootSim
out=$(./obj_dir/uprocBootSim)
echo "$out"
echo "$out" | grep -q "TEST PASSED"

/* uprocBoot.f */
logic/uprocPkg.sv
logic/bootImage.sv
logic/memController.sv
logic/pauseNetwork.sv
logic/uprocBoot.sv
dv/spiEepromModel.sv
dv/uprocBootTb.sv
